//--- rtl/accel_settings.svh
`ifndef ACCEL_SETTINGS_SVH
`define ACCEL_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Multiplier array
// ---------------------------------------------------------------------------
`define ACCEL_NUM_MUL 8

// Operand width, product is twice as wide
`define ACCEL_OP_WIDTH 8

// ---------------------------------------------------------------------------
// CR address map
// ---------------------------------------------------------------------------
`define ACCEL_CR_BASE 32'h0040_0F00

// One word per multiplier CR, control CR right after them
`define ACCEL_CR_STRIDE 32'h4
`define ACCEL_CR_CTRL_OFS 32'h20

`endif

//--- rtl/accel_cr_pkg.sv
`include "accel_settings.svh"

package accel_cr_pkg;

    // -----------------------------------------------------------------------
    // CR addresses as seen by the core
    // -----------------------------------------------------------------------
    typedef enum logic [31:0] {
        CR_MUL_0    = `ACCEL_CR_BASE + 0 * `ACCEL_CR_STRIDE,
        CR_MUL_1    = `ACCEL_CR_BASE + 1 * `ACCEL_CR_STRIDE,
        CR_MUL_2    = `ACCEL_CR_BASE + 2 * `ACCEL_CR_STRIDE,
        CR_MUL_3    = `ACCEL_CR_BASE + 3 * `ACCEL_CR_STRIDE,
        CR_MUL_4    = `ACCEL_CR_BASE + 4 * `ACCEL_CR_STRIDE,
        CR_MUL_5    = `ACCEL_CR_BASE + 5 * `ACCEL_CR_STRIDE,
        CR_MUL_6    = `ACCEL_CR_BASE + 6 * `ACCEL_CR_STRIDE,
        CR_MUL_7    = `ACCEL_CR_BASE + 7 * `ACCEL_CR_STRIDE,
        CR_MUL_CTRL = `ACCEL_CR_BASE + `ACCEL_CR_CTRL_OFS
    } t_cr_addr;

    // -----------------------------------------------------------------------
    // CR storage
    // -----------------------------------------------------------------------
    // Multiplier CR layout
    //   [7:0]   multiplicand
    //   [15:8]  multiplier
    //   [31:16] product
    //
    // Control CR layout
    //   [2n]    start of multiplier n
    //   [2n+1]  sticky done of multiplier n
    //   [31:16] always zero
    typedef struct packed {
        logic [31:0]                        cr_mul_ctrl;
        logic [`ACCEL_NUM_MUL-1:0][31:0]    cr_mul;
    } t_accel_cr;

endpackage

//--- rtl/accel_mul_pkg.sv
`include "accel_settings.svh"

package accel_mul_pkg;

    // -----------------------------------------------------------------------
    // CR memory to multiplier
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic                           start;
        logic [`ACCEL_OP_WIDTH-1:0]     multiplicand;
        logic [`ACCEL_OP_WIDTH-1:0]     multiplier;
    } t_mul_req;

    // -----------------------------------------------------------------------
    // Multiplier to CR memory
    // -----------------------------------------------------------------------
    // Result is only meaningful while valid is high
    typedef struct packed {
        logic                           valid;
        logic [2*`ACCEL_OP_WIDTH-1:0]   result;
    } t_mul_rsp;

    // One entry per multiplier, index n is slot n
    typedef t_mul_req [`ACCEL_NUM_MUL-1:0] t_core_mul_req;
    typedef t_mul_rsp [`ACCEL_NUM_MUL-1:0] t_mul_core_rsp;

endpackage

//--- rtl/accel_int8_mul.sv
`include "accel_settings.svh"

module accel_int8_mul (
    input  logic                    clk,
    input  logic                    rst,
    input  accel_mul_pkg::t_mul_req req,
    output accel_mul_pkg::t_mul_rsp rsp
);

    localparam int OP_W  = `ACCEL_OP_WIDTH;
    localparam int CNT_W = $clog2(OP_W);

    logic             busy;
    logic [CNT_W-1:0] bit_cnt;
    logic             valid_q;
    logic             take;

    // Datapath, shifted in place each step
    logic [2*OP_W-1:0] mcand_sh;
    logic [OP_W-1:0]   mplier_sh;
    logic [2*OP_W-1:0] acc;

    // Starts during a multiply are dropped
    assign take = req.start & ~busy;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (take) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                // Last multiplier bit consumed
                if (bit_cnt == CNT_W'(OP_W - 1)) begin
                    busy    <= 1'b0;
                    valid_q <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Shift-add datapath
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (take) begin
            mcand_sh  <= {{OP_W{1'b0}}, req.multiplicand};
            mplier_sh <= req.multiplier;
            acc       <= '0;
        end else if (busy) begin
            if (mplier_sh[0]) begin
                acc <= acc + mcand_sh;
            end
            mcand_sh  <= mcand_sh << 1;
            mplier_sh <= mplier_sh >> 1;
        end
    end

    // acc stays put until the next accepted start
    assign rsp.valid  = valid_q;
    assign rsp.result = acc;

    a_valid_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        valid_q |=> !valid_q
    ) else $error("valid longer than one cycle");

    a_valid_after_busy: assert property (
        @(posedge clk) disable iff (rst)
        valid_q |-> $past(busy)
    ) else $error("valid without a preceding busy cycle");

endmodule

//--- rtl/accel_mul_farm.sv
`include "accel_settings.svh"

module accel_mul_farm (
    input  logic                         clk,
    input  logic                         rst,
    input  accel_mul_pkg::t_core_mul_req core_mul_req,
    output accel_mul_pkg::t_mul_core_rsp mul_core_rsp
);

    // ------------------------------------------------------------------------
    // One sequential multiplier per CR slot
    // ------------------------------------------------------------------------
    // Slot n takes request n and answers on response n
    for (genvar i = 0; i < `ACCEL_NUM_MUL; i++) begin : g_mul
        accel_int8_mul u_mul (
            .clk (clk),
            .rst (rst),
            .req (core_mul_req[i]),
            .rsp (mul_core_rsp[i])
        );
    end

endmodule

//--- rtl/accel_cr_mem.sv
`include "accel_settings.svh"

module accel_cr_mem (
    input  logic                         clk,
    input  logic                         rst,

    // Core side
    input  logic [31:0]                  data,
    input  logic [31:0]                  address,
    input  logic                         wren,
    input  logic                         rden,
    output logic [31:0]                  q,

    // Multiplier farm side
    input  accel_mul_pkg::t_mul_core_rsp mul_core_rsp,
    output accel_mul_pkg::t_core_mul_req core_mul_req
);

    import accel_cr_pkg::*;

    localparam int NUM_MUL = `ACCEL_NUM_MUL;
    localparam int OP_W    = `ACCEL_OP_WIDTH;

    t_accel_cr          accel_cr;
    t_accel_cr          next_cr;

    logic [NUM_MUL-1:0] mul_hit;
    logic               ctrl_hit;
    logic               addr_hit;
    logic [31:0]        rd_data;
    logic [NUM_MUL-1:0] start_vec;

    // ------------------------------------------------------------------------
    // Address decode, shared by reads and writes
    // ------------------------------------------------------------------------
    always_comb begin : addr_decode
        mul_hit  = '0;
        ctrl_hit = 1'b0;
        case (address)
            CR_MUL_0:    mul_hit[0] = 1'b1;
            CR_MUL_1:    mul_hit[1] = 1'b1;
            CR_MUL_2:    mul_hit[2] = 1'b1;
            CR_MUL_3:    mul_hit[3] = 1'b1;
            CR_MUL_4:    mul_hit[4] = 1'b1;
            CR_MUL_5:    mul_hit[5] = 1'b1;
            CR_MUL_6:    mul_hit[6] = 1'b1;
            CR_MUL_7:    mul_hit[7] = 1'b1;
            CR_MUL_CTRL: ctrl_hit   = 1'b1;
            default:     ;
        endcase
    end

    assign addr_hit = (|mul_hit) | ctrl_hit;

    // ------------------------------------------------------------------------
    // CR update
    // ------------------------------------------------------------------------
    always_comb begin : cr_next
        next_cr = accel_cr;
        for (int i = 0; i < NUM_MUL; i++) begin
            // Start bits live for a single cycle
            next_cr.cr_mul_ctrl[2*i] = 1'b0;

            // Core only owns the operand half
            if (wren && mul_hit[i]) begin
                next_cr.cr_mul[i][2*OP_W-1:0] = data[2*OP_W-1:0];
            end

            // Product capture and sticky done
            if (mul_core_rsp[i].valid) begin
                next_cr.cr_mul[i][4*OP_W-1:2*OP_W] = mul_core_rsp[i].result;
                next_cr.cr_mul_ctrl[2*i+1]         = 1'b1;
            end

            // A new start wins over a done arriving on the same edge
            if (wren && ctrl_hit && data[2*i]) begin
                next_cr.cr_mul_ctrl[2*i]   = 1'b1;
                next_cr.cr_mul_ctrl[2*i+1] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            accel_cr <= '0;
        end else begin
            accel_cr <= next_cr;
        end
    end

    // ------------------------------------------------------------------------
    // Core read, unmapped addresses give zero
    // ------------------------------------------------------------------------
    always_comb begin : rd_mux
        rd_data = '0;
        for (int i = 0; i < NUM_MUL; i++) begin
            if (mul_hit[i]) begin
                rd_data = accel_cr.cr_mul[i];
            end
        end
        if (ctrl_hit) begin
            rd_data = accel_cr.cr_mul_ctrl;
        end
    end

    // q holds between reads
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (rden) begin
            q <= rd_data;
        end
    end

    // Requests straight from the registered CRs
    always_comb begin : req_map
        for (int i = 0; i < NUM_MUL; i++) begin
            start_vec[i]                 = accel_cr.cr_mul_ctrl[2*i];
            core_mul_req[i].start        = start_vec[i];
            core_mul_req[i].multiplicand = accel_cr.cr_mul[i][OP_W-1:0];
            core_mul_req[i].multiplier   = accel_cr.cr_mul[i][2*OP_W-1:OP_W];
        end
    end

    // Start is a pulse, never two cycles in a row
    a_start_pulse: assert property (
        @(posedge clk) disable iff (rst)
        (start_vec & $past(start_vec)) == '0
    ) else $error("start bit held high for two cycles");

    a_unmapped_read: assert property (
        @(posedge clk) disable iff (rst)
        (rden && !addr_hit) |=> (q == '0)
    ) else $error("unmapped read returned non-zero data");

endmodule

//--- rtl/accel_top.sv
module accel_top (
    input  logic        clk,
    input  logic        rst,

    // Core CR port
    input  logic [31:0] data,
    input  logic [31:0] address,
    input  logic        wren,
    input  logic        rden,
    output logic [31:0] q
);

    import accel_mul_pkg::*;

    t_core_mul_req core_mul_req;
    t_mul_core_rsp mul_core_rsp;

    // ------------------------------------------------------------------------
    // CR memory, core facing
    // ------------------------------------------------------------------------
    accel_cr_mem u_cr_mem (
        .clk          (clk),
        .rst          (rst),
        .data         (data),
        .address      (address),
        .wren         (wren),
        .rden         (rden),
        .q            (q),
        .mul_core_rsp (mul_core_rsp),
        .core_mul_req (core_mul_req)
    );

    // ------------------------------------------------------------------------
    // Multiplier array
    // ------------------------------------------------------------------------
    accel_mul_farm u_mul_farm (
        .clk          (clk),
        .rst          (rst),
        .core_mul_req (core_mul_req),
        .mul_core_rsp (mul_core_rsp)
    );

endmodule

//--- testbench/accel_tb.sv
`include "accel_settings.svh"

module accel_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import accel_cr_pkg::*;

    localparam int NUM_MUL    = `ACCEL_NUM_MUL;
    localparam int OP_W       = `ACCEL_OP_WIDTH;
    localparam int NUM_ROUNDS = 30;

    // About 40 start and poll rounds of up to 60 cycles each, plus margin
    localparam int unsigned TIMEOUT_CYCLES = 4000;

    logic        clk;
    logic        rst;
    logic [31:0] data;
    logic [31:0] address;
    logic        wren;
    logic        rden;
    logic [31:0] q;

    logic        rden_seen;
    int unsigned cycle_cnt;
    logic [31:0] lfsr_state;

    // Expected read results in issue order
    logic [31:0] exp_q[$];
    logic [31:0] mask_q[$];
    string       msg_q[$];

    // CR contents as the core should see them
    logic [31:0]     model_mul[NUM_MUL];
    logic [31:0]     model_ctrl;
    logic [OP_W-1:0] op_a[NUM_MUL];
    logic [OP_W-1:0] op_b[NUM_MUL];

    accel_top uut (
        .clk     (clk),
        .rst     (rst),
        .data    (data),
        .address (address),
        .wren    (wren),
        .rden    (rden),
        .q       (q)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------------------
    // Reference model helpers
    // ------------------------------------------------------------------------
    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
        return b;
    endfunction

    function automatic logic [2*OP_W-1:0] expected_product(input logic [OP_W-1:0] a,
                                                           input logic [OP_W-1:0] b);
        logic [2*OP_W-1:0] p;
        p = {{OP_W{1'b0}}, a} * {{OP_W{1'b0}}, b};
        return p;
    endfunction

    function automatic logic [31:0] mul_addr(input int slot);
        return `ACCEL_CR_BASE + 32'(slot) * `ACCEL_CR_STRIDE;
    endfunction

    function automatic logic [31:0] start_bit(input int slot);
        return 32'h1 << (2 * slot);
    endfunction

    function automatic logic [31:0] done_bit(input int slot);
        return 32'h2 << (2 * slot);
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string msg);
        if (got !== expected) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, msg, got, expected);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // ------------------------------------------------------------------------
    // Compare process, q is stable half a cycle after the sampling edge
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        rden_seen <= rden;
    end

    always @(negedge clk) begin
        if (rden_seen) begin
            if (exp_q.size() == 0) begin
                $display("A read completed but no expected value was queued for it");
                $display("CHECKS FAILED");
                $fatal(1, "expectation queue empty");
            end else begin
                check_value(q & mask_q[0], exp_q[0] & mask_q[0], msg_q[0]);
                void'(exp_q.pop_front());
                void'(mask_q.pop_front());
                void'(msg_q.pop_front());
            end
        end
    end

    // ------------------------------------------------------------------------
    // Bus tasks, entered 1 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic write_cr(input logic [31:0] addr, input logic [31:0] wdata);
        address = addr;
        data    = wdata;
        wren    = 1'b1;
        @(posedge clk);
        #1;
        wren = 1'b0;
    endtask

    task automatic read_cr(input logic [31:0] addr, input logic [31:0] expected,
                           input logic [31:0] mask, input string msg,
                           output logic [31:0] rdata);
        exp_q.push_back(expected);
        mask_q.push_back(mask);
        msg_q.push_back(msg);
        address = addr;
        rden    = 1'b1;
        @(posedge clk);
        #1;
        rden  = 1'b0;
        rdata = q;
    endtask

    task automatic expect_cr(input logic [31:0] addr, input logic [31:0] expected,
                             input string msg);
        logic [31:0] rdata;
        read_cr(addr, expected, 32'hFFFF_FFFF, msg, rdata);
    endtask

    // Slots in flight may show start or done, all other bits follow the model
    task automatic wait_done(input logic [31:0] done_mask);
        logic [31:0] ctrl;
        logic [31:0] busy_mask;
        ctrl      = '0;
        busy_mask = done_mask | (done_mask >> 1);
        while ((ctrl & done_mask) != done_mask) begin
            read_cr(CR_MUL_CTRL, model_ctrl, ~busy_mask, "done poll", ctrl);
        end
    endtask

    task automatic compare_all_crs(input string msg);
        for (int i = 0; i < NUM_MUL; i++) begin
            expect_cr(mul_addr(i), model_mul[i], $sformatf("%s, CR_MUL_%0d", msg, i));
        end
        expect_cr(CR_MUL_CTRL, model_ctrl, $sformatf("%s, CR_MUL_CTRL", msg));
    endtask

    task automatic load_operands(input int slot);
        op_a[slot] = random_byte();
        op_b[slot] = random_byte();
        write_cr(mul_addr(slot), {16'h0000, op_b[slot], op_a[slot]});
        model_mul[slot][15:0] = {op_b[slot], op_a[slot]};
    endtask

    task automatic record_result(input int slot);
        model_mul[slot][31:16] = expected_product(op_a[slot], op_b[slot]);
        model_ctrl = model_ctrl | done_bit(slot);
    endtask

    // ------------------------------------------------------------------------
    // Test sequences
    // ------------------------------------------------------------------------
    task automatic reset_values();
        check_value(q, '0, "q after reset");
        compare_all_crs("reset value");
    endtask

    task automatic operand_readback();
        logic [OP_W-1:0] a;
        logic [OP_W-1:0] b;
        for (int i = 0; i < NUM_MUL; i++) begin
            a = random_byte();
            b = random_byte();
            // Product half ignores core writes
            write_cr(mul_addr(i), {random_byte(), random_byte(), b, a});
            model_mul[i] = {16'h0000, b, a};
        end
        compare_all_crs("operand readback");
    endtask

    task automatic single_multiply(input int slot);
        load_operands(slot);
        write_cr(CR_MUL_CTRL, start_bit(slot));
        wait_done(done_bit(slot));
        record_result(slot);
        expect_cr(CR_MUL_CTRL, model_ctrl, "single multiply, done bits");
        expect_cr(mul_addr(slot), model_mul[slot], "single multiply, product");
    endtask

    task automatic all_slots_rounds();
        logic [31:0] start_all;
        logic [31:0] done_all;
        start_all = '0;
        done_all  = '0;
        for (int i = 0; i < NUM_MUL; i++) begin
            start_all = start_all | start_bit(i);
            done_all  = done_all | done_bit(i);
        end
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            for (int i = 0; i < NUM_MUL; i++) begin
                load_operands(i);
            end
            write_cr(CR_MUL_CTRL, start_all);
            model_ctrl = model_ctrl & ~done_all;
            // Start bits still up for this one cycle, all done bits cleared
            expect_cr(CR_MUL_CTRL, start_all, $sformatf("round %0d, control after start", r));
            wait_done(done_all);
            for (int i = 0; i < NUM_MUL; i++) begin
                record_result(i);
            end
            compare_all_crs($sformatf("round %0d", r));
        end
    endtask

    task automatic start_while_busy(input int slot);
        logic [OP_W-1:0] first_a;
        logic [OP_W-1:0] first_b;
        load_operands(slot);
        first_a = op_a[slot];
        first_b = op_b[slot];
        write_cr(CR_MUL_CTRL, start_bit(slot));
        model_ctrl = model_ctrl & ~done_bit(slot);
        // New operands and a second start while the first multiply runs
        load_operands(slot);
        write_cr(CR_MUL_CTRL, start_bit(slot));
        wait_done(done_bit(slot));
        model_mul[slot][31:16] = expected_product(first_a, first_b);
        model_ctrl = model_ctrl | done_bit(slot);
        expect_cr(mul_addr(slot), model_mul[slot], "start while busy, product");
        // A late second result would show up here
        repeat (12) @(posedge clk);
        #1;
        compare_all_crs("start while busy, after idle");
    endtask

    task automatic unmapped_access();
        logic [31:0] bad_addr[4];
        bad_addr = '{`ACCEL_CR_BASE + 32'h24, `ACCEL_CR_BASE + 32'h2,
                     `ACCEL_CR_BASE - 32'h4, 32'h0};
        for (int i = 0; i < 4; i++) begin
            expect_cr(bad_addr[i], '0, $sformatf("unmapped read at %h", bad_addr[i]));
        end
        for (int i = 0; i < 4; i++) begin
            write_cr(bad_addr[i], 32'hFFFF_FFFF);
        end
        compare_all_crs("after unmapped writes");
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        data       = '0;
        address    = '0;
        wren       = 1'b0;
        rden       = 1'b0;
        cycle_cnt  = 0;
        lfsr_state = 32'h2d97;
        model_ctrl = '0;
        for (int i = 0; i < NUM_MUL; i++) begin
            model_mul[i] = '0;
            op_a[i]      = '0;
            op_b[i]      = '0;
        end

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_values();
        operand_readback();
        single_multiply(3);
        all_slots_rounds();
        start_while_busy(5);
        unmapped_access();

        // Let the last read reach the compare process
        repeat (2) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("Run ended with %0d reads never compared", exp_q.size());
            $display("CHECKS FAILED");
            $fatal(1, "reads left unchecked");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- project.f
+incdir+rtl
rtl/accel_cr_pkg.sv
rtl/accel_mul_pkg.sv
rtl/accel_int8_mul.sv
rtl/accel_mul_farm.sv
rtl/accel_cr_mem.sv
rtl/accel_top.sv
testbench/accel_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = accel_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
